//--- rv_pkg.sv
package rv_pkg;

	localparam int xlen = 64;
	localparam int dmem_words = 64;
	localparam int dmem_aw = $clog2(dmem_words); // doubleword index bits

	// rv64i major opcodes
	localparam logic [6:0] op_op        = 7'b011_0011;
	localparam logic [6:0] op_op_32     = 7'b011_1011;
	localparam logic [6:0] op_op_imm    = 7'b001_0011;
	localparam logic [6:0] op_op_imm_32 = 7'b001_1011;
	localparam logic [6:0] op_load      = 7'b000_0011;
	localparam logic [6:0] op_store     = 7'b010_0011;
	localparam logic [6:0] op_branch    = 7'b110_0011;
	localparam logic [6:0] op_jal       = 7'b110_1111;
	localparam logic [6:0] op_jalr      = 7'b110_0111;
	localparam logic [6:0] op_lui       = 7'b011_0111;
	localparam logic [6:0] op_auipc     = 7'b001_0111;

	typedef enum logic [4:0] {
		alu_add     = 5'd0,
		alu_addw    = 5'd1,
		alu_sll     = 5'd2,
		alu_sllw    = 5'd3,
		alu_sra     = 5'd4,
		alu_sraw    = 5'd5,
		alu_srl     = 5'd6,
		alu_srlw    = 5'd7,
		alu_and     = 5'd8,
		alu_or      = 5'd9,
		alu_xor     = 5'd10,
		alu_slt     = 5'd11,
		alu_sltu    = 5'd12,
		alu_eq      = 5'd13,
		alu_ne      = 5'd14,
		alu_ge      = 5'd15,
		alu_geu     = 5'd16,
		alu_sub     = 5'd17,
		alu_subw    = 5'd18,
		alu_illegal = 5'h1f // result forced to zero
	} alu_op_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm; // bits 31:12
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} insn_t;

	typedef enum logic [1:0] {
		src1_reg  = 2'd0,
		src1_zero = 2'd1,
		src1_pc   = 2'd2
	} src1_sel_t;

	typedef enum logic [1:0] {
		src2_reg  = 2'd0,
		src2_imm  = 2'd1,
		src2_four = 2'd2
	} src2_sel_t;

	typedef struct packed {
		src1_sel_t  src1_sel;
		src2_sel_t  src2_sel;
		alu_op_t    alu_op;
		logic       branch;
		logic       jalr;
		logic       mem_write;
		logic       mem_read;
		logic       reg_write;
		logic [2:0] funct3; // branch condition
	} dec_ctrl_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] imm;
		dec_ctrl_t       ctrl;
	} id_ex_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0]      rd;
		logic [xlen-1:0] result; // alu result or memory address
		logic [xlen-1:0] store_data;
		logic            mem_read;
		logic            mem_write;
		logic            reg_write;
	} ex_wb_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0]      rd;
		logic [xlen-1:0] data;
		logic            we;
	} retire_t;

endpackage

//--- fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            jump,
	input  logic [xlen-1:0] jump_target,
	input  logic            resolve,
	input  logic [xlen-1:0] resolve_pc,
	input  logic            bubble,
	output logic [xlen-1:0] imem_addr,
	input  logic [31:0]     imem_data,
	output logic            if_valid,
	output logic [xlen-1:0] if_pc,
	output insn_t           if_insn
);

	logic [xlen-1:0] pc;
	logic            waiting; // parked until execute resolves

	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc       <= '0;
			waiting  <= 1'b0;
			if_valid <= 1'b0;
		end else begin
			if (jump) begin
				pc      <= jump_target; // jal redirect from decode
				waiting <= 1'b0;
			end else if (resolve) begin
				pc      <= resolve_pc;
				waiting <= 1'b0;
			end else if (bubble) begin
				waiting <= 1'b1; // jalr or branch in decode
			end else if (!waiting) begin
				pc <= pc + xlen'(4);
			end
			// the word fetched alongside a control-flow op is dropped
			if_valid <= !(bubble || waiting);
		end
	end

	always_ff @(posedge clk) begin
		if_pc   <= pc;
		if_insn <= imem_data;
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            if_valid,
	input  logic [xlen-1:0] if_pc,
	input  insn_t           if_insn,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	output logic [4:0]      rs1_addr,
	output logic [4:0]      rs2_addr,
	output logic            bubble,
	output logic            jump,
	output logic [xlen-1:0] jump_target,
	output logic            id_valid,
	output id_ex_t          id_ex
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            alt; // instruction bit 30
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] imm;
	dec_ctrl_t       ctrl;
	alu_op_t         alu_op;

	assign opcode   = if_insn.r_fmt.opcode;
	assign funct3   = if_insn.r_fmt.funct3;
	assign alt      = if_insn.r_fmt.funct7[5];
	assign rs1_addr = if_insn.r_fmt.rs1;
	assign rs2_addr = if_insn.r_fmt.rs2;

	assign imm_i = {{(xlen-12){if_insn.i_fmt.imm[11]}}, if_insn.i_fmt.imm};
	assign imm_s = {{(xlen-12){if_insn.s_fmt.imm_hi[6]}}, if_insn.s_fmt.imm_hi,
		if_insn.s_fmt.imm_lo};
	assign imm_b = {{(xlen-13){if_insn.b_fmt.imm_12}}, if_insn.b_fmt.imm_12,
		if_insn.b_fmt.imm_11, if_insn.b_fmt.imm_10_5, if_insn.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {{(xlen-32){if_insn.u_fmt.imm[19]}}, if_insn.u_fmt.imm, 12'b0};
	assign imm_j = {{(xlen-21){if_insn.j_fmt.imm_20}}, if_insn.j_fmt.imm_20,
		if_insn.j_fmt.imm_19_12, if_insn.j_fmt.imm_11, if_insn.j_fmt.imm_10_1, 1'b0};

	// any jump or branch kills the word fetched behind it
	assign bubble      = if_valid && (opcode == op_jal || opcode == op_jalr ||
		opcode == op_branch);
	assign jump        = if_valid && opcode == op_jal;
	assign jump_target = if_pc + imm_j;

	always_comb begin
		ctrl           = '0;
		ctrl.src1_sel  = src1_reg;
		ctrl.src2_sel  = src2_reg;
		ctrl.alu_op    = alu_op;
		ctrl.funct3    = funct3;
		imm            = imm_i;
		case (opcode)
			op_op, op_op_32: begin
				ctrl.reg_write = 1'b1;
			end
			op_op_imm, op_op_imm_32: begin
				ctrl.src2_sel  = src2_imm;
				ctrl.reg_write = 1'b1;
			end
			op_load: begin
				ctrl.src2_sel  = src2_imm;
				ctrl.mem_read  = (funct3 == 3'b011); // ld only
				ctrl.reg_write = (funct3 == 3'b011);
			end
			op_store: begin
				ctrl.src2_sel  = src2_imm;
				ctrl.mem_write = (funct3 == 3'b011); // sd only
				imm            = imm_s;
			end
			op_branch: begin
				ctrl.branch = 1'b1;
				imm         = imm_b;
			end
			op_jal: begin
				ctrl.src1_sel  = src1_pc; // link value pc+4
				ctrl.src2_sel  = src2_four;
				ctrl.reg_write = 1'b1;
				imm            = imm_j;
			end
			op_jalr: begin
				ctrl.src1_sel  = src1_pc;
				ctrl.src2_sel  = src2_four;
				ctrl.jalr      = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_lui: begin
				ctrl.src1_sel  = src1_zero;
				ctrl.src2_sel  = src2_imm;
				ctrl.reg_write = 1'b1;
				imm            = imm_u;
			end
			op_auipc: begin
				ctrl.src1_sel  = src1_pc;
				ctrl.src2_sel  = src2_imm;
				ctrl.reg_write = 1'b1;
				imm            = imm_u;
			end
			default: ctrl.alu_op = alu_illegal; // retires as a no-op
		endcase
	end

	always_comb begin
		alu_op = alu_add; // address and link arithmetic
		case (opcode)
			op_op: begin
				case (funct3)
					3'b000:  alu_op = alt ? alu_sub : alu_add;
					3'b001:  alu_op = alu_sll;
					3'b010:  alu_op = alu_slt;
					3'b011:  alu_op = alu_sltu;
					3'b100:  alu_op = alu_xor;
					3'b101:  alu_op = alt ? alu_sra : alu_srl;
					3'b110:  alu_op = alu_or;
					default: alu_op = alu_and;
				endcase
			end
			op_op_32: begin
				case (funct3)
					3'b000:  alu_op = alt ? alu_subw : alu_addw;
					3'b001:  alu_op = alu_sllw;
					3'b101:  alu_op = alt ? alu_sraw : alu_srlw;
					default: alu_op = alu_illegal;
				endcase
			end
			op_op_imm: begin
				case (funct3)
					3'b000:  alu_op = alu_add;
					3'b001:  alu_op = alu_sll;
					3'b010:  alu_op = alu_slt;
					3'b011:  alu_op = alu_sltu;
					3'b100:  alu_op = alu_xor;
					3'b101:  alu_op = alt ? alu_sra : alu_srl;
					3'b110:  alu_op = alu_or;
					default: alu_op = alu_and;
				endcase
			end
			op_op_imm_32: begin
				case (funct3)
					3'b000:  alu_op = alu_addw;
					3'b001:  alu_op = alu_sllw;
					3'b101:  alu_op = alt ? alu_sraw : alu_srlw;
					default: alu_op = alu_illegal;
				endcase
			end
			op_branch: begin
				case (funct3)
					3'b000:  alu_op = alu_eq;
					3'b001:  alu_op = alu_ne;
					3'b100:  alu_op = alu_slt;
					3'b101:  alu_op = alu_ge;
					3'b110:  alu_op = alu_sltu;
					3'b111:  alu_op = alu_geu;
					default: alu_op = alu_illegal;
				endcase
			end
			default: alu_op = alu_add;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			id_valid <= 1'b0;
		else
			id_valid <= if_valid;
	end

	always_ff @(posedge clk) begin
		id_ex.pc       <= if_pc;
		id_ex.rs1      <= rs1_addr;
		id_ex.rs2      <= rs2_addr;
		id_ex.rd       <= if_insn.r_fmt.rd;
		id_ex.rs1_data <= rs1_data;
		id_ex.rs2_data <= rs2_data;
		id_ex.imm      <= imm;
		id_ex.ctrl     <= ctrl;
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic [4:0]      rs1_addr,
	input  logic [4:0]      rs2_addr,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	input  logic            wb_we,
	input  logic [4:0]      wb_rd,
	input  logic [xlen-1:0] wb_data
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_we && wb_rd != 5'd0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// same-cycle write is visible on the read ports
	always_comb begin
		if (rs1_addr == 5'd0)
			rs1_data = '0;
		else if (wb_we && wb_rd == rs1_addr)
			rs1_data = wb_data;
		else
			rs1_data = regs[rs1_addr];
		if (rs2_addr == 5'd0)
			rs2_data = '0;
		else if (wb_we && wb_rd == rs2_addr)
			rs2_data = wb_data;
		else
			rs2_data = regs[rs2_addr];
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            id_valid,
	input  id_ex_t          id_ex,
	input  logic            wb_we,
	input  logic [4:0]      wb_rd,
	input  logic [xlen-1:0] wb_data,
	output logic            resolve,
	output logic [xlen-1:0] resolve_pc,
	output logic            ex_valid,
	output ex_wb_t          ex_wb
);

	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] result;
	logic [xlen-1:0] jalr_sum;
	logic            eq;
	logic            lt;
	logic            ltu;
	logic            taken;

	function automatic logic [xlen-1:0] sext32(input logic [31:0] w);
		return {{(xlen-32){w[31]}}, w};
	endfunction

	// bypass from the instruction now in writeback
	assign rs1_val = (wb_we && wb_rd != 5'd0 && wb_rd == id_ex.rs1) ? wb_data : id_ex.rs1_data;
	assign rs2_val = (wb_we && wb_rd != 5'd0 && wb_rd == id_ex.rs2) ? wb_data : id_ex.rs2_data;

	always_comb begin
		case (id_ex.ctrl.src1_sel)
			src1_reg:  op_a = rs1_val;
			src1_pc:   op_a = id_ex.pc;
			default:   op_a = '0;
		endcase
		case (id_ex.ctrl.src2_sel)
			src2_reg:  op_b = rs2_val;
			src2_imm:  op_b = id_ex.imm;
			src2_four: op_b = xlen'(4);
			default:   op_b = '0;
		endcase
	end

	assign eq  = (op_a == op_b);
	assign lt  = ($signed(op_a) < $signed(op_b));
	assign ltu = (op_a < op_b);

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_add:  result = op_a + op_b;
			alu_addw: result = sext32(op_a[31:0] + op_b[31:0]);
			alu_sub:  result = op_a - op_b;
			alu_subw: result = sext32(op_a[31:0] - op_b[31:0]);
			alu_sll:  result = op_a << op_b[5:0];
			alu_sllw: result = sext32(op_a[31:0] << op_b[4:0]);
			alu_srl:  result = op_a >> op_b[5:0];
			alu_srlw: result = sext32(op_a[31:0] >> op_b[4:0]);
			alu_sra:  result = $signed(op_a) >>> op_b[5:0];
			alu_sraw: result = sext32($signed(op_a[31:0]) >>> op_b[4:0]);
			alu_and:  result = op_a & op_b;
			alu_or:   result = op_a | op_b;
			alu_xor:  result = op_a ^ op_b;
			alu_slt:  result = xlen'(lt);
			alu_sltu: result = xlen'(ltu);
			alu_eq:   result = xlen'(eq);
			alu_ne:   result = xlen'(!eq);
			alu_ge:   result = xlen'(!lt);
			alu_geu:  result = xlen'(!ltu);
			default:  result = '0;
		endcase
	end

	// branch operands are rs1/rs2, so the compare flags apply directly
	always_comb begin
		case (id_ex.ctrl.funct3)
			3'b000:  taken = eq;
			3'b001:  taken = !eq;
			3'b100:  taken = lt;
			3'b101:  taken = !lt;
			3'b110:  taken = ltu;
			3'b111:  taken = !ltu;
			default: taken = 1'b0;
		endcase
	end

	assign jalr_sum = rs1_val + id_ex.imm;
	assign resolve  = id_valid && (id_ex.ctrl.branch || id_ex.ctrl.jalr);

	always_comb begin
		if (id_ex.ctrl.jalr)
			resolve_pc = {jalr_sum[xlen-1:1], 1'b0};
		else if (taken)
			resolve_pc = id_ex.pc + id_ex.imm;
		else
			resolve_pc = id_ex.pc + xlen'(4); // fall through
	end

	always_ff @(posedge clk) begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= id_valid;
	end

	always_ff @(posedge clk) begin
		ex_wb.pc         <= id_ex.pc;
		ex_wb.rd         <= id_ex.rd;
		ex_wb.result     <= result;
		ex_wb.store_data <= rs2_val;
		ex_wb.mem_read   <= id_ex.ctrl.mem_read;
		ex_wb.mem_write  <= id_ex.ctrl.mem_write;
		ex_wb.reg_write  <= id_ex.ctrl.reg_write;
	end

endmodule

//--- mem_wb_stage.sv
`timescale 1ns/1ns

module mem_wb_stage
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            ex_valid,
	input  ex_wb_t          ex_wb,
	output logic            wb_we,
	output logic [4:0]      wb_rd,
	output logic [xlen-1:0] wb_data,
	output logic            retire_valid,
	output retire_t         retire
);

	logic [xlen-1:0]    dmem [dmem_words];
	logic [dmem_aw-1:0] index;

	assign index = ex_wb.result[3 +: dmem_aw]; // doubleword index, wraps

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dmem_words; i++)
				dmem[i] <= '0;
		end else if (ex_valid && ex_wb.mem_write) begin
			dmem[index] <= ex_wb.store_data;
		end
	end

	assign wb_we   = ex_valid && ex_wb.reg_write;
	assign wb_rd   = ex_wb.rd;
	assign wb_data = ex_wb.mem_read ? dmem[index] : ex_wb.result; // ld reads same cycle

	always_ff @(posedge clk) begin
		if (reset)
			retire_valid <= 1'b0;
		else
			retire_valid <= ex_valid;
	end

	always_ff @(posedge clk) begin
		retire.pc   <= ex_wb.pc;
		retire.rd   <= ex_wb.rd;
		retire.data <= wb_data;
		retire.we   <= ex_wb.reg_write;
	end

endmodule

//--- rv_core.sv
`timescale 1ns/1ns

module rv_core
	import rv_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	output logic [xlen-1:0] imem_addr,
	input  logic [31:0]     imem_data,
	output logic            retire_valid,
	output retire_t         retire
);

	logic            jump;
	logic [xlen-1:0] jump_target;
	logic            resolve;
	logic [xlen-1:0] resolve_pc;
	logic            bubble;
	logic            if_valid;
	logic [xlen-1:0] if_pc;
	insn_t           if_insn;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic            id_valid;
	id_ex_t          id_ex;
	logic            ex_valid;
	ex_wb_t          ex_wb;
	logic            wb_we;     // writeback port, also the bypass source
	logic [4:0]      wb_rd;
	logic [xlen-1:0] wb_data;

	fetch_stage u_fetch (
		.clk, .reset, .jump, .jump_target, .resolve, .resolve_pc, .bubble,
		.imem_addr, .imem_data, .if_valid, .if_pc, .if_insn
	);

	decode_stage u_decode (
		.clk, .reset, .if_valid, .if_pc, .if_insn, .rs1_data, .rs2_data,
		.rs1_addr, .rs2_addr, .bubble, .jump, .jump_target, .id_valid, .id_ex
	);

	reg_file u_reg_file (
		.clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.wb_we, .wb_rd, .wb_data
	);

	execute_stage u_execute (
		.clk, .reset, .id_valid, .id_ex, .wb_we, .wb_rd, .wb_data,
		.resolve, .resolve_pc, .ex_valid, .ex_wb
	);

	mem_wb_stage u_mem_wb (
		.clk, .reset, .ex_valid, .ex_wb, .wb_we, .wb_rd, .wb_data,
		.retire_valid, .retire
	);

endmodule

//--- tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store}; // sd
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
	input logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

task automatic emit(input logic [31:0] w);
	prog[prog_len]  = w;
	names[prog_len] = section;
	prog_len++;
endtask

// lui + addiw gives the sign-extended 32-bit value
task automatic load32(input logic [4:0] rd, input logic [31:0] v);
	logic [31:0] hi;
	hi = v + 32'h800;
	emit(u_type(hi[31:12], rd, op_lui));
	emit(i_type(v[11:0], rd, 3'b000, rd, op_op_imm_32));
endtask

task automatic load64(input logic [4:0] rd, input logic [63:0] v);
	load32(rd, v[63:32]);
	emit(i_type(12'd32, rd, 3'b001, rd, op_op_imm));
	load32(5'd31, v[31:0]);
	emit(i_type(12'd32, 5'd31, 3'b001, 5'd31, op_op_imm));
	emit(i_type(12'd32, 5'd31, 3'b101, 5'd31, op_op_imm)); // zero-extend low half
	emit(r_type(7'd0, 5'd31, rd, 3'b110, rd, op_op));
endtask

function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
	input logic [63:0] a, input logic [63:0] b);
	logic signed [63:0] sa;
	sa = a;
	case (f3)
		3'b000:  return alt ? a - b : a + b;
		3'b001:  return a << b[5:0];
		3'b010:  return {63'd0, $signed(a) < $signed(b)};
		3'b011:  return {63'd0, a < b};
		3'b100:  return a ^ b;
		3'b101:  return alt ? 64'(sa >>> b[5:0]) : a >> b[5:0];
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
	input logic [63:0] a, input logic [63:0] b);
	logic [31:0]        r;
	logic signed [31:0] sa;
	sa = a[31:0];
	case (f3)
		3'b000:  r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
		3'b001:  r = a[31:0] << b[4:0];
		default: r = alt ? 32'(sa >>> b[4:0]) : a[31:0] >> b[4:0];
	endcase
	return {{32{r[31]}}, r};
endfunction

// sequential ISA execution, one expected retirement per instruction
task automatic run_model();
	logic [63:0] regs [32];
	logic [63:0] mem [64];
	logic [63:0] pc, next, a, b, val, addr, ii, si, bi, ui, ji;
	logic [31:0] w;
	logic        we, taken;
	retire_t     e;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	for (int i = 0; i < 64; i++)
		mem[i] = '0;
	pc = '0;
	while (pc[63:2] < 62'(prog_len)) begin
		w  = prog[pc[9:2]];
		a  = regs[w[19:15]];
		b  = regs[w[24:20]];
		ii = {{52{w[31]}}, w[31:20]};
		si = {{52{w[31]}}, w[31:25], w[11:7]};
		bi = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		ui = {{32{w[31]}}, w[31:12], 12'd0};
		ji = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		next = pc + 64'd4;
		we   = 1'b1;
		val  = '0;
		case (w[6:0])
			op_op:        val = alu64(w[14:12], w[30], a, b);
			op_op_imm:    val = alu64(w[14:12], w[14:12] == 3'b101 && w[30], a, ii);
			op_op_32:     val = alu32(w[14:12], w[30], a, b);
			op_op_imm_32: val = alu32(w[14:12], w[14:12] == 3'b101 && w[30], a, ii);
			op_lui:       val = ui;
			op_auipc:     val = pc + ui;
			op_jal: begin
				val  = pc + 64'd4;
				next = pc + ji;
			end
			op_jalr: begin
				val  = pc + 64'd4;
				addr = a + ii;
				next = {addr[63:1], 1'b0};
			end
			op_load: begin
				addr = a + ii;
				val  = mem[addr[8:3]];
			end
			op_store: begin
				we   = 1'b0;
				addr = a + si;
				mem[addr[8:3]] = b;
			end
			op_branch: begin
				we = 1'b0;
				case (w[14:12])
					3'b000:  taken = a == b;
					3'b001:  taken = a != b;
					3'b100:  taken = $signed(a) < $signed(b);
					3'b101:  taken = $signed(a) >= $signed(b);
					3'b110:  taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken)
					next = pc + bi;
			end
			default: we = 1'b0;
		endcase
		e.pc   = pc;
		e.rd   = w[11:7];
		e.data = val;
		e.we   = we;
		exp_q.push_back(e);
		exp_name.push_back(names[pc[9:2]]);
		if (we && w[11:7] != 5'd0)
			regs[w[11:7]] = val;
		pc = next;
	end
endtask

`endif

//--- tb_top.sv
`timescale 1ns/1ns

module tb_top
	import rv_pkg::*;
();

	logic        clk;
	logic        reset;
	logic [63:0] imem_addr;
	logic [31:0] imem_data;
	logic        retire_valid;
	retire_t     retire;

	logic [31:0] prog [256];
	string       names [256];
	int          prog_len = 0;
	string       section;
	retire_t     exp_q [$];
	string       exp_name [$];
	int          checked = 0;
	logic        built = 1'b0;

	`include "tb_rv_model.svh"

	rv_core DUT (
		.clk, .reset, .imem_addr, .imem_data, .retire_valid, .retire
	);

	// words past the program end decode as no-ops
	assign imem_data = (imem_addr[63:2] < 62'(prog_len)) ? prog[imem_addr[9:2]] : 32'd0;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic build_program();
		logic [2:0] br_f3 [6];
		logic [4:0] sh;
		br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		sh = 5'($urandom);
		section = "load";
		for (int r = 1; r <= 4; r++)
			load64(5'(r), {$urandom, $urandom});
		section = "alu_reg";
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5, op_op));
		emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd6, op_op));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7, op_op));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd8, op_op));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd9, op_op));
		emit(r_type(7'h00, 5'd3, 5'd1, 3'b001, 5'd10, op_op));
		emit(r_type(7'h00, 5'd3, 5'd1, 3'b101, 5'd11, op_op));
		emit(r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd12, op_op));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd13, op_op));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd14, op_op));
		emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd15, op_op));
		section = "alu_imm";
		for (int f = 0; f < 8; f++)
			if (f != 1 && f != 5)
				emit(i_type(12'($urandom), 5'd1, 3'(f), 5'd16, op_op_imm));
		emit(i_type({6'b000000, sh, 1'b1}, 5'd2, 3'b001, 5'd17, op_op_imm));
		emit(i_type({6'b000000, sh, 1'b0}, 5'd2, 3'b101, 5'd17, op_op_imm));
		emit(i_type({6'b010000, sh, 1'b1}, 5'd2, 3'b101, 5'd17, op_op_imm));
		section = "x0";
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, op_op));
		emit(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd18, op_op)); // reads x0
		section = "word";
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd19, op_op_32));
		emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd19, op_op_32));
		emit(r_type(7'h00, 5'd3, 5'd1, 3'b001, 5'd19, op_op_32));
		emit(r_type(7'h00, 5'd3, 5'd2, 3'b101, 5'd19, op_op_32));
		emit(r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd19, op_op_32));
		emit(i_type(12'($urandom), 5'd1, 3'b000, 5'd19, op_op_imm_32));
		emit(i_type({7'h00, sh}, 5'd2, 3'b001, 5'd19, op_op_imm_32));
		emit(i_type({7'h00, sh}, 5'd2, 3'b101, 5'd19, op_op_imm_32));
		emit(i_type({7'h20, sh}, 5'd2, 3'b101, 5'd19, op_op_imm_32));
		section = "forward";
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd20, op_op));
		emit(r_type(7'h00, 5'd1, 5'd20, 3'b000, 5'd21, op_op));  // distance one
		emit(r_type(7'h20, 5'd21, 5'd20, 3'b000, 5'd22, op_op)); // distance one and two
		emit(r_type(7'h00, 5'd22, 5'd20, 3'b100, 5'd23, op_op));
		section = "memory";
		emit(i_type(12'd64, 5'd0, 3'b000, 5'd24, op_op_imm));
		emit(s_type(12'd8, 5'd3, 5'd24));
		emit(i_type(12'd8, 5'd24, 3'b011, 5'd25, op_load));
		emit(r_type(7'h00, 5'd1, 5'd25, 3'b000, 5'd26, op_op));
		emit(s_type(12'hff8, 5'd4, 5'd24));
		emit(i_type(12'hff8, 5'd24, 3'b011, 5'd27, op_load));
		section = "upper";
		emit(u_type(20'($urandom), 5'd28, op_lui));
		emit(u_type(20'($urandom), 5'd29, op_auipc));
		section = "jump";
		emit(j_type(21'd8, 5'd30));
		emit(i_type(12'd1, 5'd5, 3'b000, 5'd5, op_op_imm)); // skipped
		emit(u_type(20'd0, 5'd14, op_auipc));
		emit(i_type(12'd12, 5'd14, 3'b000, 5'd15, op_jalr));
		emit(i_type(12'd1, 5'd5, 3'b000, 5'd5, op_op_imm)); // skipped
		emit(r_type(7'h00, 5'd0, 5'd15, 3'b000, 5'd16, op_op));
		section = "branch";
		for (int f = 0; f < 6; f++) begin
			emit(b_type(13'd8, 5'd2, 5'd1, br_f3[f]));
			emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, op_op_imm));
			emit(b_type(13'd8, 5'd1, 5'd2, br_f3[f]));
			emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, op_op_imm));
			emit(b_type(13'd8, 5'd1, 5'd1, br_f3[f]));
			emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, op_op_imm));
		end
		emit(i_type(12'd1, 5'd0, 3'b000, 5'd5, op_op_imm));
	endtask

	// nothing retires and fetch stays at address 0 while reset is held
	task automatic check_reset_state();
		assert (retire_valid == 1'b0) else begin
			$display("retire_valid was set during reset");
			$display("Verification failed");
			$fatal(1, "retire during reset");
		end
		assert (imem_addr == 64'd0) else begin
			$display("** Error: reset imem_addr expected %h actual %h", 64'd0, imem_addr);
			$display("Verification failed");
			$fatal(1, "fetch address during reset");
		end
	endtask

	initial begin
		void'($urandom(39));
		reset = 1'b1;
		build_program();
		run_model();
		built = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#1 check_reset_state();
		end
		reset = 1'b0;
	end

	initial begin
		wait (built);
		repeat (prog_len * 4 + 50) @(posedge clk);
		$display("retirement stalled before the program completed");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	task automatic report_value(input string what, input logic [63:0] expv,
		input logic [63:0] actv);
		$display("** Error: %s %s expected %h actual %h", exp_name[checked], what, expv, actv);
		$display("Verification failed");
		$fatal(1, "retirement mismatch");
	endtask

	always @(negedge clk) begin
		if (!reset && retire_valid) begin
			assert (retire.pc == exp_q[checked].pc)
				else report_value("pc", exp_q[checked].pc, retire.pc);
			assert (retire.we == exp_q[checked].we)
				else report_value("we", 64'(exp_q[checked].we), 64'(retire.we));
			if (exp_q[checked].we) begin
				assert (retire.rd == exp_q[checked].rd)
					else report_value("rd", 64'(exp_q[checked].rd), 64'(retire.rd));
				assert (retire.data == exp_q[checked].data)
					else report_value("data", exp_q[checked].data, retire.data);
			end
			checked++;
			if (checked == exp_q.size()) begin
				$display("Verification passed");
				$finish;
			end
		end
	end

endmodule

//--- sim.f
+incdir+.
rv_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_wb_stage.sv
rv_core.sv
tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sim.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim
